// ==== build.f ====
source/ahb_pkg.sv
source/ahb_ram_slave.sv
source/ahb_gpio_slave.sv
source/ahb_matrix_ctrl.sv
source/ahb_matrix.sv
tests/ahb_matrix_sva.sv
tests/tb_ahb_matrix.sv

// ==== source/ahb_gpio_slave.sv ====
module ahb_gpio_slave #(
    parameter int N_SWITCHES   = 10,
    parameter int N_BUTTONS    = 4,
    parameter int N_RED_LEDS   = 10,
    parameter int N_GREEN_LEDS = 8
) (
    input  logic                    hclk,
    input  logic                    rst,
    input  logic                    hsel,
    input  logic                    hready,
    input  ahb_pkg::ahb_addr_t      haddr_phase,
    input  logic [31:0]             hwdata,
    input  logic [N_SWITCHES-1:0]   io_switches,
    input  logic [N_BUTTONS-1:0]    io_buttons,
    output ahb_pkg::ahb_resp_t      resp,
    output logic [N_RED_LEDS-1:0]   io_red_leds,
    output logic [N_GREEN_LEDS-1:0] io_green_leds,
    output logic [31:0]             io_hex
);

    logic       active;
    logic       write_r;
    logic [2:0] offset_r;  // Word offset inside the region
    logic [31:0] read_data;

    // ----------------------------------------
    // Accepted transfer
    // ----------------------------------------
    always_ff @(posedge hclk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (hready) begin
            active <= hsel;
        end
    end

    always_ff @(posedge hclk) begin
        if (hready && hsel) begin
            offset_r <= haddr_phase.haddr[4:2];
            write_r  <= haddr_phase.hwrite;
        end
    end

    // ----------------------------------------
    // Output registers
    // ----------------------------------------
    always_ff @(posedge hclk) begin
        if (rst) begin
            io_red_leds   <= '0;
            io_green_leds <= '0;
            io_hex        <= '0;
        end else if (active && hready && write_r) begin
            case (offset_r)
                ahb_pkg::GPIO_RED_LEDS:   io_red_leds   <= hwdata[N_RED_LEDS-1:0];
                ahb_pkg::GPIO_GREEN_LEDS: io_green_leds <= hwdata[N_GREEN_LEDS-1:0];
                ahb_pkg::GPIO_HEX:        io_hex        <= hwdata;
                default: ;  // Inputs and holes ignore writes
            endcase
        end
    end

    // Zero-extended read back with holes reading 0
    always_comb begin
        case (offset_r)
            ahb_pkg::GPIO_SWITCHES:   read_data = 32'(io_switches);
            ahb_pkg::GPIO_BUTTONS:    read_data = 32'(io_buttons);
            ahb_pkg::GPIO_RED_LEDS:   read_data = 32'(io_red_leds);
            ahb_pkg::GPIO_GREEN_LEDS: read_data = 32'(io_green_leds);
            ahb_pkg::GPIO_HEX:        read_data = io_hex;
            default:                  read_data = '0;
        endcase
    end

    always_comb begin
        resp.hrdata    = (active && !write_r) ? read_data : '0;
        resp.hreadyout = 1'b1;  // Zero wait states
        resp.hresp     = 1'b0;
    end

endmodule

// ==== source/ahb_matrix.sv ====
module ahb_matrix #(
    parameter int RESET_RAM_ADDR_WIDTH = 6,
    parameter int RAM_ADDR_WIDTH       = 8,
    parameter int RAM_WAIT_STATES      = 2,
    parameter int N_SWITCHES           = 10,
    parameter int N_BUTTONS            = 4,
    parameter int N_RED_LEDS           = 10,
    parameter int N_GREEN_LEDS         = 8
) (
    input  logic                      hclk,
    input  logic                      rst,
    input  ahb_pkg::ahb_addr_t        haddr_phase,
    input  logic [31:0]               hwdata,
    output logic [31:0]               hrdata,
    output logic                      hready,
    output logic                      hresp,
    input  logic [N_SWITCHES-1:0]     io_switches,
    input  logic [N_BUTTONS-1:0]      io_buttons,
    output logic [N_RED_LEDS-1:0]     io_red_leds,
    output logic [N_GREEN_LEDS-1:0]   io_green_leds,
    output logic [31:0]               io_hex
);

    logic [ahb_pkg::SLAVE_COUNT-1:0] hsel;  // Address phase select
    ahb_pkg::ahb_resp_t              slave_resp [ahb_pkg::SLAVE_COUNT];

    ahb_matrix_ctrl ctrl (
        .hclk        (hclk),
        .rst         (rst),
        .haddr_phase (haddr_phase),
        .slave_resp  (slave_resp),
        .hsel        (hsel),
        .hrdata      (hrdata),
        .hready      (hready),
        .hresp       (hresp)
    );

    // Zero-wait boot memory
    ahb_ram_slave #(
        .ADDR_WIDTH  (RESET_RAM_ADDR_WIDTH),
        .WAIT_STATES (0)
    ) reset_ram (
        .hclk        (hclk),
        .rst         (rst),
        .hsel        (hsel[ahb_pkg::SEL_RESET_RAM]),
        .hready      (hready),
        .haddr_phase (haddr_phase),
        .hwdata      (hwdata),
        .resp        (slave_resp[ahb_pkg::SEL_RESET_RAM])
    );

    ahb_ram_slave #(
        .ADDR_WIDTH  (RAM_ADDR_WIDTH),
        .WAIT_STATES (RAM_WAIT_STATES)
    ) ram (
        .hclk        (hclk),
        .rst         (rst),
        .hsel        (hsel[ahb_pkg::SEL_RAM]),
        .hready      (hready),
        .haddr_phase (haddr_phase),
        .hwdata      (hwdata),
        .resp        (slave_resp[ahb_pkg::SEL_RAM])
    );

    ahb_gpio_slave #(
        .N_SWITCHES   (N_SWITCHES),
        .N_BUTTONS    (N_BUTTONS),
        .N_RED_LEDS   (N_RED_LEDS),
        .N_GREEN_LEDS (N_GREEN_LEDS)
    ) gpio (
        .hclk          (hclk),
        .rst           (rst),
        .hsel          (hsel[ahb_pkg::SEL_GPIO]),
        .hready        (hready),
        .haddr_phase   (haddr_phase),
        .hwdata        (hwdata),
        .io_switches   (io_switches),
        .io_buttons    (io_buttons),
        .resp          (slave_resp[ahb_pkg::SEL_GPIO]),
        .io_red_leds   (io_red_leds),
        .io_green_leds (io_green_leds),
        .io_hex        (io_hex)
    );

endmodule

// ==== source/ahb_matrix_ctrl.sv ====
module ahb_matrix_ctrl (
    input  logic                            hclk,
    input  logic                            rst,
    input  ahb_pkg::ahb_addr_t              haddr_phase,
    input  ahb_pkg::ahb_resp_t              slave_resp [ahb_pkg::SLAVE_COUNT],
    output logic [ahb_pkg::SLAVE_COUNT-1:0] hsel,
    output logic [31:0]                     hrdata,
    output logic                            hready,
    output logic                            hresp
);

    logic [ahb_pkg::SLAVE_COUNT-1:0] addr_match;
    logic                            xfer_active;
    logic                            unmapped;

    logic [ahb_pkg::SLAVE_COUNT-1:0] sel_r;       // Data phase select
    logic                            err_first;   // Error cycle one with hready low
    logic                            err_second;  // Error cycle two with hready high

    // ----------------------------------------
    // Address phase decode
    // ----------------------------------------

    // Regions do not overlap, so at most one bit is set
    always_comb begin
        addr_match = '0;
        addr_match[ahb_pkg::SEL_RESET_RAM] =
            (haddr_phase.haddr[28:22] == ahb_pkg::RESET_RAM_MATCH);
        addr_match[ahb_pkg::SEL_RAM] =
            (haddr_phase.haddr[28:26] == ahb_pkg::RAM_MATCH);
        addr_match[ahb_pkg::SEL_GPIO] =
            (haddr_phase.haddr[28:22] == ahb_pkg::GPIO_MATCH);
    end

    // SEQ counts as NONSEQ and BUSY as IDLE
    assign xfer_active = (haddr_phase.htrans & ahb_pkg::HTRANS_NONSEQ) != ahb_pkg::HTRANS_IDLE;

    assign hsel     = xfer_active ? addr_match : '0;
    assign unmapped = xfer_active && (addr_match == '0);

    // ----------------------------------------
    // Data phase state
    // ----------------------------------------
    always_ff @(posedge hclk) begin
        if (rst) begin
            sel_r      <= '0;
            err_first  <= 1'b0;
            err_second <= 1'b0;
        end else begin
            err_second <= err_first;
            if (hready) begin
                sel_r     <= hsel;
                err_first <= unmapped;
            end else begin
                err_first <= 1'b0;  // First error cycle never stalls twice
            end
        end
    end

    // ----------------------------------------
    // Response to the master
    // ----------------------------------------
    always_comb begin
        hrdata = '0;
        hready = 1'b1;
        hresp  = 1'b0;

        for (int i = 0; i < ahb_pkg::SLAVE_COUNT; i++) begin
            if (sel_r[i]) begin
                hrdata = slave_resp[i].hrdata;
                hready = slave_resp[i].hreadyout;
                hresp  = slave_resp[i].hresp;
            end
        end

        // Two-cycle ERROR for unmapped transfers
        if (err_first) begin
            hready = 1'b0;
            hresp  = 1'b1;
        end else if (err_second) begin
            hready = 1'b1;
            hresp  = 1'b1;
        end
    end

endmodule

// ==== source/ahb_pkg.sv ====
package ahb_pkg;

    // ----------------------------------------
    // Bus structs
    // ----------------------------------------

    // Address phase from the master
    typedef struct packed {
        logic [31:0] haddr;
        logic [1:0]  htrans;
        logic        hwrite;
    } ahb_addr_t;

    // Data phase answer of one slave
    typedef struct packed {
        logic [31:0] hrdata;
        logic        hreadyout;
        logic        hresp;
    } ahb_resp_t;

    // BUSY and SEQ fold into these two transfer types
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    localparam int SLAVE_COUNT = 3;

    localparam int SEL_RESET_RAM = 0;
    localparam int SEL_RAM       = 1;
    localparam int SEL_GPIO      = 2;

    localparam logic [6:0] RESET_RAM_MATCH = 7'h7f;  // Bits 28:22 select 0x1fc00000
    localparam logic [2:0] RAM_MATCH       = 3'h0;   // Bits 28:26 select the low 64 MB
    localparam logic [6:0] GPIO_MATCH      = 7'h7e;  // Bits 28:22 select 0x1f800000

    // GPIO word offsets
    localparam logic [2:0] GPIO_SWITCHES   = 3'd0;
    localparam logic [2:0] GPIO_BUTTONS    = 3'd1;
    localparam logic [2:0] GPIO_RED_LEDS   = 3'd2;
    localparam logic [2:0] GPIO_GREEN_LEDS = 3'd3;
    localparam logic [2:0] GPIO_HEX        = 3'd4;

endpackage

// ==== source/ahb_ram_slave.sv ====
module ahb_ram_slave #(
    parameter int ADDR_WIDTH  = 8,
    parameter int WAIT_STATES = 0
) (
    input  logic               hclk,
    input  logic               rst,
    input  logic               hsel,
    input  logic               hready,
    input  ahb_pkg::ahb_addr_t haddr_phase,
    input  logic [31:0]        hwdata,
    output ahb_pkg::ahb_resp_t resp
);

    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [31:0]           mem [2**ADDR_WIDTH];

    logic                  active;    // Data phase in progress
    logic [CNT_W-1:0]      wait_cnt;  // Wait cycles still to go
    logic [ADDR_WIDTH-1:0] addr_r;
    logic                  write_r;
    logic                  ready_out;

    // ----------------------------------------
    // Transfer tracking
    // ----------------------------------------
    always_ff @(posedge hclk) begin
        if (rst) begin
            active   <= 1'b0;
            wait_cnt <= '0;
        end else if (hready) begin
            active   <= hsel;
            wait_cnt <= hsel ? CNT_W'(WAIT_STATES) : '0;
        end else if (active && wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    // Word address wraps at the memory depth
    always_ff @(posedge hclk) begin
        if (hready && hsel) begin
            addr_r  <= haddr_phase.haddr[ADDR_WIDTH+1:2];
            write_r <= haddr_phase.hwrite;
        end
    end

    assign ready_out = !active || (wait_cnt == '0);

    // ----------------------------------------
    // Memory array
    // ----------------------------------------

    // hready is only high here on the last data phase cycle
    always_ff @(posedge hclk) begin
        if (active && hready && write_r) begin
            mem[addr_r] <= hwdata;
        end
    end

    always_comb begin
        resp.hrdata    = (active && !write_r) ? mem[addr_r] : '0;
        resp.hreadyout = ready_out;
        resp.hresp     = 1'b0;  // OKAY only
    end

endmodule

// ==== tests/ahb_matrix_sva.sv ====
module ahb_matrix_sva #(
    parameter int N_RED_LEDS   = 10,
    parameter int N_GREEN_LEDS = 8
) (
    input logic                    hclk,
    input logic                    rst,
    input logic                    hready,
    input logic                    hresp,
    input logic [N_RED_LEDS-1:0]   io_red_leds,
    input logic [N_GREEN_LEDS-1:0] io_green_leds,
    input logic [31:0]             io_hex
);
    timeunit 1ns;
    timeprecision 1ps;

    // ----------------------------------------
    // Master side response
    // ----------------------------------------

    // First ERROR cycle is always followed by the second
    error_two_cycles: assert property (
        @(posedge hclk) disable iff (rst)
        (hresp && !hready) |=> (hresp && hready)
    ) else $error("ERROR response did not finish with hready and hresp high");

    ready_after_reset: assert property (
        @(posedge hclk) $fell(rst) |-> hready
    ) else $error("hready low in the first cycle after reset");

    // ----------------------------------------
    // GPIO outputs
    // ----------------------------------------
    outputs_known: assert property (
        @(posedge hclk) disable iff (rst)
        !$isunknown({io_red_leds, io_green_leds, io_hex})
    ) else $error("GPIO output has an unknown bit");

endmodule

bind ahb_matrix ahb_matrix_sva #(
    .N_RED_LEDS   (N_RED_LEDS),
    .N_GREEN_LEDS (N_GREEN_LEDS)
) sva (
    .hclk          (hclk),
    .rst           (rst),
    .hready        (hready),
    .hresp         (hresp),
    .io_red_leds   (io_red_leds),
    .io_green_leds (io_green_leds),
    .io_hex        (io_hex)
);

// ==== tests/tb_ahb_matrix.sv ====
module tb_ahb_matrix;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_XFERS     = 400;
    localparam int RESET_DEPTH = 64;   // 2**RESET_RAM_ADDR_WIDTH
    localparam int RAM_DEPTH   = 256;  // 2**RAM_ADDR_WIDTH
    localparam int RAM_WAITS   = 2;
    localparam int TIMEOUT_NS  = (N_XFERS * 6 + 20) * 10;  // Worst case 6 cycles per transfer

    logic               hclk;
    logic               rst;
    ahb_pkg::ahb_addr_t haddr_phase;
    logic [31:0]        hwdata;
    logic [31:0]        hrdata;
    logic               hready;
    logic               hresp;
    logic [9:0]         io_switches;
    logic [3:0]         io_buttons;
    logic [9:0]         io_red_leds;
    logic [7:0]         io_green_leds;
    logic [31:0]        io_hex;

    integer seed = 6;

    // Reference model
    logic [31:0] reset_mem [int];
    logic [31:0] ram_mem [int];
    logic [9:0]  red_model;
    logic [7:0]  green_model;
    logic [31:0] hex_model;

    ahb_matrix DUT (
        .hclk          (hclk),
        .rst           (rst),
        .haddr_phase   (haddr_phase),
        .hwdata        (hwdata),
        .hrdata        (hrdata),
        .hready        (hready),
        .hresp         (hresp),
        .io_switches   (io_switches),
        .io_buttons    (io_buttons),
        .io_red_leds   (io_red_leds),
        .io_green_leds (io_green_leds),
        .io_hex        (io_hex)
    );

    initial begin
        hclk = 1'b0;
        forever #5 hclk = ~hclk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the transfers did not complete in the expected time");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic next_cycle();
        @(posedge hclk);
        #1;
    endtask

    // One word transfer with an IDLE address phase behind its data phase
    task automatic transfer(input logic [31:0] addr, input logic write,
                            input logic [31:0] wdata, input int exp_low,
                            input logic exp_err, output logic [31:0] rdata);
        int low;
        low = 0;
        haddr_phase.haddr  = addr;
        haddr_phase.htrans = ahb_pkg::HTRANS_NONSEQ;
        haddr_phase.hwrite = write;
        @(negedge hclk);
        check("hready", hready, 1'b1);  // No data phase still pending
        next_cycle();
        haddr_phase.htrans = ahb_pkg::HTRANS_IDLE;
        hwdata = wdata;
        @(negedge hclk);
        while (hready !== 1'b1) begin
            check("hresp", hresp, exp_err);
            low++;
            @(negedge hclk);
        end
        check("hresp", hresp, exp_err);
        check("hready low cycles", low, exp_low);
        rdata = hrdata;
        next_cycle();
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        int          target;
        int          idx;
        int          key;
        int          off;
        int          exp_low;
        logic        exp_err;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] exp_rd;

        rst         = 1'b1;
        haddr_phase = '0;
        hwdata      = '0;
        io_switches = '0;
        io_buttons  = '0;
        red_model   = '0;
        green_model = '0;
        hex_model   = '0;
        repeat (4) @(posedge hclk);
        #1 rst = 1'b0;

        @(negedge hclk);
        check("hready", hready, 1'b1);
        check("hresp", hresp, 1'b0);
        check("io_red_leds", io_red_leds, '0);
        check("io_green_leds", io_green_leds, '0);
        check("io_hex", io_hex, '0);
        next_cycle();

        for (int n = 0; n < N_XFERS; n++) begin
            target      = {$random(seed)} % 4;
            write       = $random(seed);
            wdata       = $random(seed);
            io_switches = $random(seed);  // Held for the whole transfer
            io_buttons  = $random(seed);
            exp_low     = 0;
            exp_err     = 1'b0;
            case (target)
                0: begin
                    idx  = ({$random(seed)} % 32) + ({$random(seed)} % 2) * RESET_DEPTH;
                    key  = idx % RESET_DEPTH;
                    addr = 32'h1fc0_0000 + idx * 4;
                end
                1: begin
                    idx     = ({$random(seed)} % 32) + ({$random(seed)} % 2) * RAM_DEPTH;
                    key     = idx % RAM_DEPTH;
                    addr    = idx * 4;
                    exp_low = RAM_WAITS;
                end
                2: begin
                    off  = {$random(seed)} % 8;
                    addr = 32'h1f80_0000 + off * 4;
                end
                default: begin
                    addr    = 32'h0800_0000 + ({$random(seed)} % 4096) * 4;  // Matches no region
                    exp_low = 1;
                    exp_err = 1'b1;
                end
            endcase

            transfer(addr, write, wdata, exp_low, exp_err, rdata);

            if (target == 0) begin
                if (write)
                    reset_mem[key] = wdata;
                else if (reset_mem.exists(key))
                    check("hrdata", rdata, reset_mem[key]);
            end else if (target == 1) begin
                if (write)
                    ram_mem[key] = wdata;
                else if (ram_mem.exists(key))
                    check("hrdata", rdata, ram_mem[key]);
            end else if (target == 2) begin
                if (write) begin
                    if (off == 2) red_model = wdata[9:0];
                    if (off == 3) green_model = wdata[7:0];
                    if (off == 4) hex_model = wdata;
                end else begin
                    case (off)
                        0:       exp_rd = {22'd0, io_switches};
                        1:       exp_rd = {28'd0, io_buttons};
                        2:       exp_rd = {22'd0, red_model};
                        3:       exp_rd = {24'd0, green_model};
                        4:       exp_rd = hex_model;
                        default: exp_rd = '0;
                    endcase
                    check("hrdata", rdata, exp_rd);
                end
            end

            // Outputs already show a write that ended on the last edge
            check("io_red_leds", io_red_leds, red_model);
            check("io_green_leds", io_green_leds, green_model);
            check("io_hex", io_hex, hex_model);

            repeat ({$random(seed)} % 3) next_cycle();
        end

        $display(">>> PASS");
        $finish;
    end

endmodule
